// ==== design/rr_pkg.sv ====
package rr_pkg;

    // datapath and register file geometry
    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;
    parameter int UOP_W      = 12;

    // two lanes per issue packet, two sources per lane
    parameter int NUM_LANES = 2;
    parameter int NUM_SRC   = 2 * NUM_LANES;

    // default load-use window, in execute advances after the load's slot
    parameter int LOAD_USE_DEPTH_DEF = 2;

    // one decoded lane as it comes out of the decode latch
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        logic                  is_load;
        logic [UOP_W-1:0]      uop;
    } rr_lane_t;

    // issue packet from decode
    typedef struct packed {
        rr_lane_t [NUM_LANES-1:0] lane;
    } rr_issue_t;

    // lane plus its two operands, as seen by execute
    typedef struct packed {
        rr_lane_t        op;
        logic [XLEN-1:0] rj_data;
        logic [XLEN-1:0] rk_data;
    } ex_lane_t;

    typedef struct packed {
        ex_lane_t [NUM_LANES-1:0] lane;
    } ex_pkt_t;

    // pick up a landing write-back for one register, port 1 has priority
    // r0 never takes a write
    function automatic logic [XLEN-1:0] wb_bypass(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       cur,
        input logic                  we0,
        input logic [REG_ADDR_W-1:0] waddr0,
        input logic [XLEN-1:0]       wdata0,
        input logic                  we1,
        input logic [REG_ADDR_W-1:0] waddr1,
        input logic [XLEN-1:0]       wdata1
    );
        logic [XLEN-1:0] res;
        res = cur;
        if (addr != '0) begin
            if (we0 && waddr0 == addr) begin
                res = wdata0;
            end
            if (we1 && waddr1 == addr) begin
                res = wdata1;
            end
        end
        return res;
    endfunction

endpackage

// ==== design/rr_if.sv ====
`timescale 1ns/100ps

// decode -> register-read handshake
// transfer when valid and allowin are both high on a rising edge
interface issue_if;
    import rr_pkg::*;

    logic      valid;
    rr_issue_t pkt;
    logic      allowin;

    // decode side, holds valid/pkt until accepted
    modport issuer (
        output valid,
        output pkt,
        input  allowin
    );

    // register-read stage side
    modport stage (
        input  valid,
        input  pkt,
        output allowin
    );
endinterface

// two write-back ports into the register file
interface wb_if;
    import rr_pkg::*;

    logic                  we0;
    logic [REG_ADDR_W-1:0] waddr0;
    logic [XLEN-1:0]       wdata0;
    logic                  we1;
    logic [REG_ADDR_W-1:0] waddr1;
    logic [XLEN-1:0]       wdata1;

    // write-back stage drives both ports
    modport src (
        output we0, waddr0, wdata0,
        output we1, waddr1, wdata1
    );

    // regfile and operand refresh only observe
    modport port (
        input we0, waddr0, wdata0,
        input we1, waddr1, wdata1
    );
endinterface

// ==== design/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                                             clk,
    input  logic                                             aresetn,
    wb_if.port                                               wb,
    input  logic [rr_pkg::NUM_SRC-1:0][rr_pkg::REG_ADDR_W-1:0] raddr,
    output logic [rr_pkg::NUM_SRC-1:0][rr_pkg::XLEN-1:0]       rdata
);
    import rr_pkg::*;

    // r0 has no storage
    logic [XLEN-1:0] regs [1:31];

    // both ports written in order so port 1 lands last on a collision
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.we0 && wb.waddr0 != '0) begin
                regs[wb.waddr0] <= wb.wdata0;
            end
            if (wb.we1 && wb.waddr1 != '0) begin
                regs[wb.waddr1] <= wb.wdata1;
            end
        end
    end

    // four zero-latency read ports
    // write-first, so a write landing this cycle is seen by the reader
    always_comb begin
        for (int k = 0; k < NUM_SRC; k++) begin
            if (raddr[k] == '0) begin
                // r0 hardwired
                rdata[k] = '0;
            end else begin
                rdata[k] = wb_bypass(
                    raddr[k],
                    regs[raddr[k]],
                    wb.we0,
                    wb.waddr0,
                    wb.wdata0,
                    wb.we1,
                    wb.waddr1,
                    wb.wdata1
                );
            end
        end
    end

endmodule

// ==== design/load_use_detect.sv ====
`timescale 1ns/100ps

module load_use_detect #(
    parameter int LOAD_USE_DEPTH = rr_pkg::LOAD_USE_DEPTH_DEF
) (
    input  logic                                             clk,
    input  logic                                             aresetn,
    input  logic                                             ex_allowin,
    input  logic                                             cur_load_valid,
    input  logic [rr_pkg::REG_ADDR_W-1:0]                     cur_load_rd,
    input  logic [rr_pkg::NUM_SRC-1:0][rr_pkg::REG_ADDR_W-1:0] srcs,
    output logic                                             stall
);
    import rr_pkg::*;

    // slot 0 is the load that advanced most recently
    logic [LOAD_USE_DEPTH-1:0][REG_ADDR_W-1:0] hist;
    // held load destination, zero when nothing to protect
    logic [REG_ADDR_W-1:0] cur_dst;

    assign cur_dst = cur_load_valid ? cur_load_rd : '0;

    // history moves one slot per execute advance
    // a non-load or an empty stage pushes zero
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            hist <= '0;
        end else if (ex_allowin) begin
            hist[0] <= cur_dst;
            for (int h = 1; h < LOAD_USE_DEPTH; h++) begin
                hist[h] <= hist[h-1];
            end
        end
    end

    // compare every nonzero incoming source
    // against the held load and the whole history
    always_comb begin
        stall = 1'b0;
        for (int s = 0; s < NUM_SRC; s++) begin
            if (srcs[s] != '0) begin
                if (srcs[s] == cur_dst) begin
                    stall = 1'b1;
                end
                for (int h = 0; h < LOAD_USE_DEPTH; h++) begin
                    if (srcs[s] == hist[h]) begin
                        stall = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== design/rr_stage.sv ====
`timescale 1ns/100ps

module rr_stage (
    input  logic                                       clk,
    input  logic                                       aresetn,
    input  logic                                       flush,
    input  logic                                       ex_allowin,
    issue_if.stage                                     issue,
    wb_if.port                                         wb,
    input  logic [rr_pkg::NUM_SRC-1:0][rr_pkg::XLEN-1:0] rdata,
    input  logic                                       stall,
    output logic                                       ex_valid,
    output rr_pkg::ex_pkt_t                            ex_pkt
);
    import rr_pkg::*;

    // stage can take a packet when it drains this cycle or is empty
    logic accept;
    // held packet stays put for another cycle
    logic hold;

    // free slot, no load-use hazard, no kill in progress
    assign issue.allowin = (!ex_valid || ex_allowin) && !stall && !flush;

    assign accept = issue.valid && issue.allowin;
    assign hold   = ex_valid && !ex_allowin;

    // valid bit
    // flush wins over everything, then acceptance
    // leaving without a replacement leaves a bubble behind
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (accept) begin
            ex_valid <= 1'b1;
        end else if (ex_allowin) begin
            ex_valid <= 1'b0;
        end
    end

    // payload register
    // rdata order is lane0 rj, lane0 rk, lane1 rj, lane1 rk
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                ex_pkt.lane[l].op      <= issue.pkt.lane[l];
                ex_pkt.lane[l].rj_data <= rdata[2*l];
                ex_pkt.lane[l].rk_data <= rdata[2*l+1];
            end
        end else if (hold) begin
            // operand refresh
            // a held packet tracks writes to its sources until execute takes it
            for (int l = 0; l < NUM_LANES; l++) begin
                ex_pkt.lane[l].rj_data <= wb_bypass(
                    ex_pkt.lane[l].op.rj,
                    ex_pkt.lane[l].rj_data,
                    wb.we0,
                    wb.waddr0,
                    wb.wdata0,
                    wb.we1,
                    wb.waddr1,
                    wb.wdata1
                );
                ex_pkt.lane[l].rk_data <= wb_bypass(
                    ex_pkt.lane[l].op.rk,
                    ex_pkt.lane[l].rk_data,
                    wb.we0,
                    wb.waddr0,
                    wb.wdata0,
                    wb.we1,
                    wb.waddr1,
                    wb.wdata1
                );
            end
        end
    end

endmodule

// ==== design/rr_top.sv ====
`timescale 1ns/100ps

module rr_top #(
    parameter int LOAD_USE_DEPTH = rr_pkg::LOAD_USE_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          aresetn,
    input  logic                          flush,
    // decode side
    input  logic                          in_valid,
    input  rr_pkg::rr_issue_t             in_pkt,
    output logic                          in_allowin,
    // execute side
    input  logic                          ex_allowin,
    output logic                          ex_valid,
    output rr_pkg::ex_pkt_t               ex_pkt,
    // write-back ports
    input  logic                          wb_we0,
    input  logic [rr_pkg::REG_ADDR_W-1:0] wb_waddr0,
    input  logic [rr_pkg::XLEN-1:0]       wb_wdata0,
    input  logic                          wb_we1,
    input  logic [rr_pkg::REG_ADDR_W-1:0] wb_waddr1,
    input  logic [rr_pkg::XLEN-1:0]       wb_wdata1
);
    import rr_pkg::*;

    // source addresses of the incoming packet, read data back
    logic [NUM_SRC-1:0][REG_ADDR_W-1:0] src_addr;
    logic [NUM_SRC-1:0][XLEN-1:0]       src_data;
    // load-use hazard on the incoming packet
    logic                               hz_stall;
    // lane 0 of the held packet is a live load
    logic                               held_load;

    issue_if u_issue_if ();
    wb_if    u_wb_if ();

    // decode handshake onto the interface
    assign u_issue_if.valid = in_valid;
    assign u_issue_if.pkt   = in_pkt;
    assign in_allowin       = u_issue_if.allowin;

    // write-back ports onto the interface
    assign u_wb_if.we0    = wb_we0;
    assign u_wb_if.waddr0 = wb_waddr0;
    assign u_wb_if.wdata0 = wb_wdata0;
    assign u_wb_if.we1    = wb_we1;
    assign u_wb_if.waddr1 = wb_waddr1;
    assign u_wb_if.wdata1 = wb_wdata1;

    // rj then rk for each lane
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_src
        assign src_addr[2*l]   = in_pkt.lane[l].rj;
        assign src_addr[2*l+1] = in_pkt.lane[l].rk;
    end

    // only lane 0 may carry a load
    assign held_load = ex_valid && ex_pkt.lane[0].op.is_load;

    regfile u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .wb      (u_wb_if.port),
        .raddr   (src_addr),
        .rdata   (src_data)
    );

    load_use_detect #(
        .LOAD_USE_DEPTH (LOAD_USE_DEPTH)
    ) u_load_use_detect (
        .clk            (clk),
        .aresetn        (aresetn),
        .ex_allowin     (ex_allowin),
        .cur_load_valid (held_load),
        .cur_load_rd    (ex_pkt.lane[0].op.rd),
        .srcs           (src_addr),
        .stall          (hz_stall)
    );

    rr_stage u_rr_stage (
        .clk        (clk),
        .aresetn    (aresetn),
        .flush      (flush),
        .ex_allowin (ex_allowin),
        .issue      (u_issue_if.stage),
        .wb         (u_wb_if.port),
        .rdata      (src_data),
        .stall      (hz_stall),
        .ex_valid   (ex_valid),
        .ex_pkt     (ex_pkt)
    );

endmodule

// ==== testbench/rr_asserts.sv ====
`timescale 1ns/100ps

module rr_asserts (
    input logic            clk,
    input logic            aresetn,
    input logic            flush,
    input logic            ex_allowin,
    input logic            ex_valid,
    input rr_pkg::ex_pkt_t ex_pkt,
    input logic            stall
);
    // failures so far, polled by the testbench
    int fail_count = 0;

    // a held packet keeps its lane fields
    // operands may still pick up write-back
    a_hold_stable: assert property (@(posedge clk) disable iff (!aresetn)
        (ex_valid && !ex_allowin) |=> ($stable(ex_pkt.lane[0].op) && $stable(ex_pkt.lane[1].op)))
    else begin
        $error("held packet fields changed while execute was not ready");
        fail_count++;
    end

    // nothing enters while a load-use hazard is up
    // a free stage stays empty, so a bubble follows
    a_no_accept_on_stall: assert property (@(posedge clk) disable iff (!aresetn)
        (stall && (!ex_valid || ex_allowin)) |=> !ex_valid)
    else begin
        $error("packet entered the stage during a load-use stall");
        fail_count++;
    end

    // flush empties the stage
    a_flush_kills: assert property (@(posedge clk) disable iff (!aresetn)
        flush |=> !ex_valid)
    else begin
        $error("ex_valid still high after a flush");
        fail_count++;
    end

endmodule

// ==== testbench/tb_rr_top.sv ====
`timescale 1ns/100ps

module tb_rr_top;
    import rr_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int LU_DEPTH   = 2;
    localparam int NUM_PKTS   = 200;
    localparam int SEED       = 32'h7015;
    // packets needed to read every register once
    localparam int SWEEP_PKTS = 32 / NUM_SRC;

    logic                  clk;
    logic                  aresetn;
    logic                  flush;
    logic                  in_valid;
    rr_issue_t             in_pkt;
    logic                  in_allowin;
    logic                  ex_allowin;
    logic                  ex_valid;
    ex_pkt_t               ex_pkt;
    logic                  wb_we0;
    logic [REG_ADDR_W-1:0] wb_waddr0;
    logic [XLEN-1:0]       wb_wdata0;
    logic                  wb_we1;
    logic [REG_ADDR_W-1:0] wb_waddr1;
    logic [XLEN-1:0]       wb_wdata1;

    // reference model state
    logic [XLEN-1:0]       mregs [0:31];
    logic [REG_ADDR_W-1:0] mhist [0:LU_DEPTH-1];
    logic                  m_valid;
    rr_issue_t             exp_q [$];
    int                    err_count;
    int                    sent;
    logic                  taken;

    rr_top #(
        .LOAD_USE_DEPTH (LU_DEPTH)
    ) u_rr_top (
        .clk        (clk),
        .aresetn    (aresetn),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_allowin (in_allowin),
        .ex_allowin (ex_allowin),
        .ex_valid   (ex_valid),
        .ex_pkt     (ex_pkt),
        .wb_we0     (wb_we0),
        .wb_waddr0  (wb_waddr0),
        .wb_wdata0  (wb_wdata0),
        .wb_we1     (wb_we1),
        .wb_waddr1  (wb_waddr1),
        .wb_wdata1  (wb_wdata1)
    );

    bind rr_stage rr_asserts u_rr_asserts (
        .clk        (clk),
        .aresetn    (aresetn),
        .flush      (flush),
        .ex_allowin (ex_allowin),
        .ex_valid   (ex_valid),
        .ex_pkt     (ex_pkt),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_and_stop(input string line);
        err_count++;
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_value(input logic [511:0] got, input logic [511:0] exp,
                                 input string what);
        if (got !== exp) begin
            report_and_stop($sformatf("mismatch at time %0t: %s, got %0h expected %0h",
                                      $time, what, got, exp));
        end
    endtask

    // r0 always zero
    function automatic logic [XLEN-1:0] model_read(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        return mregs[addr];
    endfunction

    // held operands track every write, so the current model value is expected
    function automatic ex_pkt_t expected_pkt(input rr_issue_t p);
        ex_pkt_t e;
        for (int l = 0; l < NUM_LANES; l++) begin
            e.lane[l].op      = p.lane[l];
            e.lane[l].rj_data = model_read(p.lane[l].rj);
            e.lane[l].rk_data = model_read(p.lane[l].rk);
        end
        return e;
    endfunction

    // destination of a load held in lane 0, zero otherwise
    function automatic logic [REG_ADDR_W-1:0] held_load_rd();
        if (m_valid && exp_q.size() > 0 && exp_q[0].lane[0].is_load) begin
            return exp_q[0].lane[0].rd;
        end
        return '0;
    endfunction

    function automatic logic hazard_expected(input rr_issue_t p);
        logic [REG_ADDR_W-1:0] src [0:3];
        logic [REG_ADDR_W-1:0] held;
        logic                  hit;
        src[0] = p.lane[0].rj;
        src[1] = p.lane[0].rk;
        src[2] = p.lane[1].rj;
        src[3] = p.lane[1].rk;
        held   = held_load_rd();
        hit    = 1'b0;
        for (int s = 0; s < 4; s++) begin
            if (src[s] != '0) begin
                if (src[s] == held) begin
                    hit = 1'b1;
                end
                for (int h = 0; h < LU_DEPTH; h++) begin
                    if (src[s] == mhist[h]) begin
                        hit = 1'b1;
                    end
                end
            end
        end
        return hit;
    endfunction

    function automatic logic expect_allowin();
        return (!m_valid || ex_allowin) && !hazard_expected(in_pkt) && !flush;
    endfunction

    // small register set keeps hazards frequent
    // an occasional full-range pick reaches the upper registers
    function automatic logic [REG_ADDR_W-1:0] pick_reg();
        if ($urandom_range(0, 7) == 0) begin
            return REG_ADDR_W'($urandom_range(0, 31));
        end
        return REG_ADDR_W'($urandom_range(0, 5));
    endfunction

    function automatic rr_issue_t random_packet(input int seq);
        rr_issue_t p;
        for (int l = 0; l < NUM_LANES; l++) begin
            // pc carries the sequence number, so order is visible
            p.lane[l].pc      = 32'h0000_1000 + seq * 8 + l * 4;
            if (seq < SWEEP_PKTS) begin
                // early packets sweep all 32 sources
                p.lane[l].rj = REG_ADDR_W'(seq * NUM_SRC + l * 2);
                p.lane[l].rk = REG_ADDR_W'(seq * NUM_SRC + l * 2 + 1);
            end else begin
                p.lane[l].rj = pick_reg();
                p.lane[l].rk = pick_reg();
            end
            p.lane[l].rd      = pick_reg();
            p.lane[l].imm     = $urandom;
            p.lane[l].is_load = (l == 0) && ($urandom_range(0, 2) == 0);
            p.lane[l].uop     = UOP_W'($urandom);
        end
        return p;
    endfunction

    task automatic drive_wb(input logic quiet);
        wb_we0    = !quiet && ($urandom_range(0, 1) == 1);
        wb_waddr0 = pick_reg();
        wb_wdata0 = $urandom;
        wb_we1    = !quiet && ($urandom_range(0, 1) == 1);
        wb_waddr1 = pick_reg();
        wb_wdata1 = $urandom;
    endtask

    // model moves on the same edge as the DUT
    always @(posedge clk) begin : model_update
        logic                  acc;
        logic [REG_ADDR_W-1:0] dst;
        if (!aresetn) begin
            m_valid = 1'b0;
            exp_q.delete();
            for (int r = 0; r < 32; r++) begin
                mregs[r] = '0;
            end
            for (int h = 0; h < LU_DEPTH; h++) begin
                mhist[h] = '0;
            end
        end else begin
            acc = in_valid && expect_allowin();
            dst = held_load_rd();
            // load history advances with execute
            if (ex_allowin) begin
                for (int h = LU_DEPTH - 1; h > 0; h--) begin
                    mhist[h] = mhist[h-1];
                end
                mhist[0] = dst;
            end
            // handed off or killed
            if (m_valid && (ex_allowin || flush)) begin
                void'(exp_q.pop_front());
            end
            // port 1 last so it wins a collision
            if (wb_we0 && wb_waddr0 != '0) begin
                mregs[wb_waddr0] = wb_wdata0;
            end
            if (wb_we1 && wb_waddr1 != '0) begin
                mregs[wb_waddr1] = wb_wdata1;
            end
            if (flush) begin
                m_valid = 1'b0;
            end else if (acc) begin
                exp_q.push_back(in_pkt);
                m_valid = 1'b1;
            end else if (ex_allowin) begin
                m_valid = 1'b0;
            end
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin : compare
        if (aresetn) begin
            compare_value(ex_valid, m_valid, "ex_valid");
            compare_value(in_allowin, expect_allowin(), "in_allowin");
            if (m_valid) begin
                compare_value(ex_pkt, expected_pkt(exp_q[0]), "ex_pkt");
            end
            compare_value(u_rr_top.u_rr_stage.u_rr_asserts.fail_count, 0, "assertion failures");
        end
    end

    initial begin : watchdog
        #(NUM_PKTS * 40 * CLK_PERIOD);
        report_and_stop("timeout: not all packets went through the stage in time");
    end

    initial begin : stimulus
        logic quiet;
        void'($urandom(SEED));
        aresetn    = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_pkt     = '0;
        ex_allowin = 1'b1;
        drive_wb(1'b1);
        err_count  = 0;
        sent       = 0;
        taken      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        aresetn = 1'b1;
        @(negedge clk);
        compare_value(ex_valid, 1'b0, "ex_valid after reset");
        compare_value(in_allowin, 1'b1, "in_allowin after reset");
        while (sent < NUM_PKTS) begin
            @(posedge clk);
            #1;
            // first packets see an all-zero register file
            quiet = (sent < SWEEP_PKTS);
            if (taken || !in_valid) begin
                in_valid = ($urandom_range(0, 9) != 0);
                in_pkt   = random_packet(sent);
            end
            ex_allowin = quiet || ($urandom_range(0, 9) < 7);
            flush      = !quiet && ($urandom_range(0, 19) == 0);
            drive_wb(quiet);
            @(negedge clk);
            taken = in_valid && in_allowin;
            if (taken) begin
                sent++;
            end
        end
        // drain the last packet
        @(posedge clk);
        #1;
        in_valid   = 1'b0;
        flush      = 1'b0;
        ex_allowin = 1'b1;
        drive_wb(1'b1);
        repeat (4) @(posedge clk);
        @(negedge clk);
        compare_value(exp_q.size(), 0, "packets left in stage");
        if (err_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            report_and_stop("errors were recorded during the run");
        end
    end

endmodule

// ==== verilog.f ====
design/rr_pkg.sv
design/rr_if.sv
design/regfile.sv
design/load_use_detect.sv
design/rr_stage.sv
design/rr_top.sv
testbench/rr_asserts.sv
testbench/tb_rr_top.sv
